// File: all.f
l2_pkg.sv
perf_pkg.sv
l2_req_if.sv
l2_arbiter.sv
l2_cache.sv
perf_counters.sv
perf_regs.sv
gpgpu_uncore.sv
tb_gpgpu_uncore.sv

// File: gpgpu_uncore.sv
`timescale 1ns/10ps

module gpgpu_uncore
	#(parameter MEM_WORDS = 256,
	parameter NUM_SETS = 16,
	parameter MISS_LATENCY = 4)

	(input               clk,
	input                reset,
	input                core0_req_valid,
	output logic         core0_req_ready,
	input                core0_req_op,
	input [31:0]         core0_req_address,
	input [31:0]         core0_req_data,
	input                core1_req_valid,
	output logic         core1_req_ready,
	input                core1_req_op,
	input [31:0]         core1_req_address,
	input [31:0]         core1_req_data,
	output logic         rsp_valid,
	output logic         rsp_core,
	output logic [31:0]  rsp_data,
	input                psel,
	input                penable,
	input                pwrite,
	input [7:0]          paddr,
	input [31:0]         pwdata,
	output logic [31:0]  prdata,
	output logic         pready,
	output logic         pslverr);

	l2_req_if core0_req();
	l2_req_if core1_req();
	l2_req_if cache_req();  // Arbiter to cache

	l2_pkg::l2rsp_packet_t rsp;
	logic [perf_pkg::NUM_COUNTERS-1:0] events;
	logic [perf_pkg::NUM_COUNTERS-1:0] enable_mask;
	logic [31:0] counts [perf_pkg::NUM_COUNTERS];
	logic clear;

	// Core ports into channels, id left for the arbiter
	assign core0_req.valid = core0_req_valid;
	assign core0_req.packet = '{core: 1'b0, op: l2_pkg::l2_op_t'(core0_req_op),
		address: core0_req_address, data: core0_req_data};
	assign core0_req_ready = core0_req.ready;
	assign core1_req.valid = core1_req_valid;
	assign core1_req.packet = '{core: 1'b0, op: l2_pkg::l2_op_t'(core1_req_op),
		address: core1_req_address, data: core1_req_data};
	assign core1_req_ready = core1_req.ready;

	// Broadcast response
	assign rsp_valid = rsp.valid;
	assign rsp_core = rsp.core;
	assign rsp_data = rsp.data;

	l2_arbiter l2_arbiter(.clk(clk), .reset(reset), .core0_req(core0_req),
		.core1_req(core1_req), .cache_req(cache_req),
		.conflict(events[perf_pkg::EV_ARB_CONFLICT]));

	l2_cache #(.MEM_WORDS(MEM_WORDS), .NUM_SETS(NUM_SETS), .MISS_LATENCY(MISS_LATENCY))
		l2_cache(.clk(clk), .reset(reset), .req(cache_req), .rsp(rsp),
		.ev_hit(events[perf_pkg::EV_L2_HIT]), .ev_miss(events[perf_pkg::EV_L2_MISS]),
		.ev_store(events[perf_pkg::EV_L2_STORE]), .ev_wait(events[perf_pkg::EV_L2_WAIT]));

	perf_counters perf_counters(.clk(clk), .reset(reset), .events(events),
		.enable_mask(enable_mask), .clear(clear), .counts(counts));

	perf_regs perf_regs(.clk(clk), .reset(reset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .counts(counts),
		.enable_mask(enable_mask), .clear(clear));

endmodule

// File: l2_arbiter.sv
`timescale 1ns/10ps

module l2_arbiter
	(input                  clk,
	input                   reset,
	l2_req_if.sink          core0_req,
	l2_req_if.sink          core1_req,
	l2_req_if.source        cache_req,
	output logic            conflict);

	logic last_grant;                 // Core granted on the last transfer
	logic grant0;
	logic grant1;
	logic both_valid;
	l2_pkg::l2req_packet_t win_packet;

	assign both_valid = core0_req.valid && core1_req.valid;

	// Core 0 wins alone, or on a tie when core 1 went last
	assign grant0 = core0_req.valid && (!core1_req.valid || last_grant);
	assign grant1 = core1_req.valid && !grant0;

	// Winner onto the cache channel
	always_comb
	begin
		win_packet = grant1 ? core1_req.packet : core0_req.packet;
		win_packet.core = grant1;  // Stamp the winning core id
	end

	assign cache_req.valid = core0_req.valid || core1_req.valid;
	assign cache_req.packet = win_packet;

	// Only the winner sees ready
	assign core0_req.ready = grant0 && cache_req.ready;
	assign core1_req.ready = grant1 && cache_req.ready;

	// Tie that actually resolves into a transfer
	assign conflict = both_valid && cache_req.ready;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_grant <= 1'b1;  // So core 0 wins the first tie
		else if (cache_req.valid && cache_req.ready)
			last_grant <= grant1;
	end

	// A stalled grant never passes to the other core before the transfer
	assert property (@(posedge clk) disable iff (reset)
		cache_req.valid && !cache_req.ready |=> $stable(cache_req.packet.core))
		else $error("l2_arbiter moved the grant while the cache stalled");

endmodule

// File: l2_cache.sv
`timescale 1ns/10ps

module l2_cache
	#(parameter MEM_WORDS = 256,
	parameter NUM_SETS = 16,
	parameter MISS_LATENCY = 4)

	(input                         clk,
	input                          reset,
	l2_req_if.sink                 req,
	output l2_pkg::l2rsp_packet_t  rsp,
	output logic                   ev_hit,
	output logic                   ev_miss,
	output logic                   ev_store,
	output logic                   ev_wait);

	localparam SET_BITS = $clog2(NUM_SETS);
	localparam TAG_BITS = 32 - SET_BITS;
	localparam MEM_BITS = $clog2(MEM_WORDS);
	localparam CNT_BITS = $clog2(MISS_LATENCY + 1);

	logic [NUM_SETS-1:0] set_valid;       // Line present per set
	logic [TAG_BITS-1:0] tags [NUM_SETS]; // Upper address bits per set
	logic [31:0] backing [MEM_WORDS];     // Memory behind the cache

	logic [CNT_BITS-1:0] countdown;       // Cycles left to response, 0 idle
	logic [SET_BITS-1:0] set_index;
	logic [TAG_BITS-1:0] req_tag;
	logic [MEM_BITS-1:0] mem_index;
	logic is_hit;
	logic is_store;
	logic transfer;

	// Held response payload, valid pulses later
	logic rsp_valid_q;
	logic rsp_core_q;
	l2_pkg::l2_op_t rsp_op_q;
	logic [31:0] rsp_data_q;

	// Address split
	assign set_index = req.packet.address[SET_BITS-1:0];
	assign req_tag = req.packet.address[31:SET_BITS];
	assign mem_index = MEM_BITS'(req.packet.address % MEM_WORDS);  // Wraps on store size

	assign is_hit = set_valid[set_index] && (tags[set_index] == req_tag);
	assign is_store = req.packet.op == l2_pkg::L2_STORE;

	assign req.ready = countdown == '0;  // One request in flight at most
	assign transfer = req.valid && req.ready;

	// Event pulses
	assign ev_hit = transfer && is_hit;
	assign ev_miss = transfer && !is_hit;
	assign ev_store = transfer && is_store;  // Also counted as hit or miss
	assign ev_wait = req.valid && !req.ready;

	// Latency and line allocation
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			set_valid <= '0;
			countdown <= '0;
			rsp_valid_q <= 1'b0;
		end
		else
		begin
			rsp_valid_q <= countdown == CNT_BITS'(1);  // Last count gives the pulse
			if (countdown != '0)
				countdown <= countdown - 1'b1;
			else if (transfer)
			begin
				countdown <= is_hit ? CNT_BITS'(1) : CNT_BITS'(MISS_LATENCY);
				set_valid[set_index] <= 1'b1;  // Loads and stores both allocate
			end
		end
	end

	// Tags, backing store and response payload
	always_ff @(posedge clk)
	begin
		if (transfer)
		begin
			tags[set_index] <= req_tag;
			rsp_core_q <= req.packet.core;
			rsp_op_q <= req.packet.op;
			rsp_data_q <= is_store ? req.packet.data : backing[mem_index];
			if (is_store)
				backing[mem_index] <= req.packet.data;  // Write through
		end
	end

	assign rsp = '{valid: rsp_valid_q, core: rsp_core_q, op: rsp_op_q, data: rsp_data_q};

	// Next request must be acceptable in the response cycle
	assert property (@(posedge clk) disable iff (reset)
		rsp.valid |-> req.ready)
		else $error("l2_cache response while not ready");

	assert property (@(posedge clk) disable iff (reset)
		countdown <= CNT_BITS'(MISS_LATENCY))
		else $error("l2_cache countdown out of range");

endmodule

// File: l2_pkg.sv
package l2_pkg;

	// Operation carried by each L2 request
	typedef enum logic
	{
		L2_LOAD  = 1'b0,
		L2_STORE = 1'b1
	} l2_op_t;

	// One request on a core or cache channel
	// Core id is filled in by the arbiter, cores leave it zero
	typedef struct packed
	{
		logic        core;     // Issuing core
		l2_op_t      op;       // Load or store
		logic [31:0] address;  // Word address
		logic [31:0] data;     // Store data, ignored on loads
	} l2req_packet_t;

	// One response, broadcast to both cores for a single cycle
	// No ready on this path
	typedef struct packed
	{
		logic        valid;    // One-cycle pulse
		logic        core;     // Core that issued the request
		l2_op_t      op;       // Echo of request op
		logic [31:0] data;     // Load data or written store data
	} l2rsp_packet_t;

endpackage

// File: l2_req_if.sv
`timescale 1ns/10ps

// One L2 request channel
// Transfer on a rising edge with valid and ready both high
// Valid and packet stay put until that edge
interface l2_req_if;
	logic valid;                     // Request present
	logic ready;                     // Sink can take it this cycle
	l2_pkg::l2req_packet_t packet;   // Request contents

	// Requesting side, a core or the arbiter output
	modport source
	(
		output valid,
		output packet,
		input  ready
	);

	// Accepting side, the arbiter inputs or the cache
	modport sink
	(
		input  valid,
		input  packet,
		output ready
	);
endinterface

// File: perf_counters.sv
`timescale 1ns/10ps

module perf_counters
	(input                               clk,
	input                                reset,
	input [perf_pkg::NUM_COUNTERS-1:0]   events,
	input [perf_pkg::NUM_COUNTERS-1:0]   enable_mask,
	input                                clear,
	output logic [31:0]                  counts [perf_pkg::NUM_COUNTERS]);

	logic [perf_pkg::NUM_COUNTERS-1:0] bump;  // Counters stepping this cycle

	// Count only unmasked events, hold at all ones
	always_comb
	begin
		for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
			bump[i] = events[i] && enable_mask[i] && (counts[i] != '1);
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
				counts[i] <= '0;
		end
		else if (clear)
		begin
			// Clear wins over an event in the same cycle
			for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
				counts[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < perf_pkg::NUM_COUNTERS; i++)
			begin
				if (bump[i])
					counts[i] <= counts[i] + 32'd1;
			end
		end
	end

endmodule

// File: perf_pkg.sv
package perf_pkg;

	// Number of counted events, one counter each
	localparam int NUM_COUNTERS = 5;

	// Bit positions in the event pulse vector
	localparam int EV_L2_HIT       = 0;
	localparam int EV_L2_MISS      = 1;
	localparam int EV_L2_STORE     = 2;
	localparam int EV_L2_WAIT      = 3;
	localparam int EV_ARB_CONFLICT = 4;

	// APB register map, byte offsets
	localparam logic [7:0] REG_ENABLE       = 8'h00;  // R/W event mask
	localparam logic [7:0] REG_CLEAR        = 8'h04;  // W only, zeroes counters
	localparam logic [7:0] REG_COUNTER_BASE = 8'h10;  // Counter i at base + 4*i

endpackage

// File: perf_regs.sv
`timescale 1ns/10ps

module perf_regs
	(input                                     clk,
	input                                      reset,
	input                                      psel,
	input                                      penable,
	input                                      pwrite,
	input [7:0]                                paddr,
	input [31:0]                               pwdata,
	output logic [31:0]                        prdata,
	output logic                               pready,
	output logic                               pslverr,
	input [31:0]                               counts [perf_pkg::NUM_COUNTERS],
	output logic [perf_pkg::NUM_COUNTERS-1:0]  enable_mask,
	output logic                               clear);

	localparam IDX_BITS = $clog2(perf_pkg::NUM_COUNTERS);
	localparam logic [7:0] COUNTER_END =
		perf_pkg::REG_COUNTER_BASE + 8'(4 * perf_pkg::NUM_COUNTERS);

	logic access;                      // APB access phase
	logic is_enable;
	logic is_clear;
	logic is_counter;
	logic [7:0] counter_offset;
	logic [IDX_BITS-1:0] counter_sel;  // Counter picked by paddr

	assign access = psel && penable;

	// Address decode
	assign is_enable = paddr == perf_pkg::REG_ENABLE;
	assign is_clear = paddr == perf_pkg::REG_CLEAR;
	assign is_counter = (paddr >= perf_pkg::REG_COUNTER_BASE) && (paddr < COUNTER_END)
		&& (paddr[1:0] == 2'b00);
	assign counter_offset = paddr - perf_pkg::REG_COUNTER_BASE;
	assign counter_sel = counter_offset[IDX_BITS+1:2];  // Word index

	assign pready = access;  // No wait states

	// Unmapped offsets and counter writes fail
	assign pslverr = access && (!(is_enable || is_clear || is_counter)
		|| (pwrite && is_counter));

	// Counters zero on the edge that ends the write
	assign clear = access && pwrite && is_clear;

	// Read mux
	always_comb
	begin
		prdata = '0;
		if (is_enable)
			prdata[perf_pkg::NUM_COUNTERS-1:0] = enable_mask;
		else if (is_counter)
			prdata = counts[counter_sel];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			enable_mask <= '1;  // All events counted
		else if (access && pwrite && is_enable)
			enable_mask <= pwdata[perf_pkg::NUM_COUNTERS-1:0];
	end

	// Master side protocol check
	assert property (@(posedge clk) disable iff (reset)
		penable |-> psel)
		else $error("perf_regs penable without psel");

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_gpgpu_uncore \
	-o tb_sim || exit 1
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Everything OK$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tb_gpgpu_uncore.sv
`timescale 1ns/10ps

module tb_gpgpu_uncore;

	localparam MEM_WORDS = 256;
	localparam NUM_SETS = 16;
	localparam MISS_LATENCY = 4;
	localparam SET_BITS = $clog2(NUM_SETS);
	localparam MAX_CMDS = 64;  // Seven words per command line

	logic clk;
	logic reset;
	logic req_valid [2];
	logic req_ready [2];
	logic req_op [2];
	logic [31:0] req_address [2];
	logic [31:0] req_data [2];
	logic rsp_valid;
	logic rsp_core;
	logic [31:0] rsp_data;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [31:0] cmds [MAX_CMDS*7];       // kind mask a0 a1 d0 d1 expected
	integer ncmd = 0;
	integer seed;
	integer errors;
	integer test_errors;
	integer tests_failed;

	// Reference model of cache, memory and counters
	logic [31:0] mem_model [MEM_WORDS];   // X until stored
	logic set_valid_m [NUM_SETS];
	logic [31:0] tag_m [NUM_SETS];
	logic [31:0] count_m [5];
	logic [4:0] mask_m;
	logic last_core;                      // Core granted last

	gpgpu_uncore #(.MEM_WORDS(MEM_WORDS), .NUM_SETS(NUM_SETS), .MISS_LATENCY(MISS_LATENCY))
		dut(.clk(clk), .reset(reset),
		.core0_req_valid(req_valid[0]), .core0_req_ready(req_ready[0]),
		.core0_req_op(req_op[0]), .core0_req_address(req_address[0]),
		.core0_req_data(req_data[0]),
		.core1_req_valid(req_valid[1]), .core1_req_ready(req_ready[1]),
		.core1_req_op(req_op[1]), .core1_req_address(req_address[1]),
		.core1_req_data(req_data[1]),
		.rsp_valid(rsp_valid), .rsp_core(rsp_core), .rsp_data(rsp_data),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr));

	initial
		clk = 1'b0;
	always
		#50 clk = ~clk;  // 100 ns period

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		begin
			assert (actual === expected)
			else
			begin
				$display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
				test_errors++;
			end
		end
	endtask

	task automatic count_event(input int idx);
		begin
			if (mask_m[idx])
				count_m[idx]++;  // Masked events are lost
		end
	endtask

	// Returns on the rising edge where core gets ready
	task automatic wait_grant(input int core);
		int n;
		begin
			n = 0;
			@(posedge clk);
			while (!req_ready[core] && n < MISS_LATENCY + 4)
			begin
				@(posedge clk);
				n++;
			end
			assert (req_ready[core])
			else
			begin
				$display("Core %0d was never granted by the arbiter", core);
				test_errors++;
			end
			check_value("other core ready", 32'd0, 32'(req_ready[1-core]));
		end
	endtask

	// One core through transfer and response, model updated at the transfer
	task automatic serve(input int core, input logic other_waiting);
		int set;
		int lat;
		int lat_exp;
		logic hit;
		logic [31:0] tag;
		logic [31:0] exp_data;
		begin
			wait_grant(core);
			set = int'(req_address[core] % NUM_SETS);
			tag = req_address[core] >> SET_BITS;
			hit = set_valid_m[set] && (tag_m[set] == tag);
			lat_exp = hit ? 1 : MISS_LATENCY;
			count_event(hit ? 0 : 1);
			if (req_op[core])
			begin
				count_event(2);
				mem_model[req_address[core] % MEM_WORDS] = req_data[core];  // Write through
			end
			if (other_waiting)
			begin
				count_event(4);  // Tie resolved here
				repeat (lat_exp)
					count_event(3);  // Loser stalls through the latency
			end
			exp_data = mem_model[req_address[core] % MEM_WORDS];
			set_valid_m[set] = 1'b1;
			tag_m[set] = tag;
			last_core = core[0];
			@(negedge clk);
			req_valid[core] = 1'b0;
			lat = 0;
			while (!rsp_valid && lat < MISS_LATENCY + 2)
			begin
				@(posedge clk);
				lat++;
				@(negedge clk);
			end
			check_value("rsp_valid", 32'd1, 32'(rsp_valid));
			check_value("latency", 32'(lat_exp), 32'(lat));
			check_value("rsp_core", 32'(core), 32'(rsp_core));
			check_value("rsp_data", exp_data, rsp_data);
		end
	endtask

	// Drives the masked cores at this falling edge
	task automatic issue(input logic [1:0] mask, input logic op, input logic [31:0] a0,
		input logic [31:0] a1, input logic [31:0] d0, input logic [31:0] d1);
		int first;
		begin
			req_address[0] = a0;
			req_address[1] = a1;
			req_data[0] = d0;
			req_data[1] = d1;
			req_op[0] = op;
			req_op[1] = op;
			req_valid[0] = mask[0];
			req_valid[1] = mask[1];
			if (mask == 2'b11)
			begin
				first = last_core ? 0 : 1;  // Core not granted last wins
				serve(first, 1'b1);
				serve(1 - first, 1'b0);
			end
			else
				serve(mask[1] ? 1 : 0, 1'b0);
		end
	endtask

	task automatic apb(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
		input logic [31:0] file_exp);
		logic is_cnt;
		logic exp_err;
		logic [31:0] exp_rd;
		begin
			is_cnt = addr >= 8'h10 && addr < 8'h24 && addr[1:0] == 2'b00;
			exp_err = !(addr == 8'h00 || addr == 8'h04 || is_cnt) || (write && is_cnt);
			exp_rd = 32'd0;
			if (addr == 8'h00)
				exp_rd = {27'd0, mask_m};
			else if (is_cnt)
				exp_rd = count_m[(addr - 8'h10) >> 2];
			psel = 1'b1;  // Setup phase
			penable = 1'b0;
			pwrite = write;
			paddr = addr;
			pwdata = wdata;
			@(negedge clk);
			penable = 1'b1;
			@(posedge clk);
			check_value("pready", 32'd1, 32'(pready));
			check_value("pslverr", 32'(exp_err), 32'(pslverr));
			if (!write && !exp_err)
			begin
				check_value("prdata", exp_rd, prdata);
				check_value("prdata vs stimulus file", file_exp, prdata);
			end
			if (write && !exp_err && addr == 8'h00)
				mask_m = wdata[4:0];
			if (write && !exp_err && addr == 8'h04)
			begin
				for (int i = 0; i < 5; i++)
					count_m[i] = 32'd0;
			end
			@(negedge clk);
			psel = 1'b0;
			penable = 1'b0;
		end
	endtask

	initial
	begin
		logic [31:0] kind;
		logic [31:0] w [7];
		seed = 32'h8b9a4c69;
		errors = 0;
		tests_failed = 0;
		reset = 1'b1;
		for (int c = 0; c < 2; c++)
		begin
			req_valid[c] = 1'b0;
			req_op[c] = 1'b0;
			req_address[c] = 32'd0;
			req_data[c] = 32'd0;
		end
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'd0;
		pwdata = 32'd0;
		for (int s = 0; s < NUM_SETS; s++)
			set_valid_m[s] = 1'b0;
		for (int i = 0; i < 5; i++)
			count_m[i] = 32'd0;
		mask_m = 5'h1f;
		last_core = 1'b1;  // Core 0 wins the first tie
		$readmemh("tb_stimulus.txt", cmds);
		while (ncmd < MAX_CMDS && cmds[ncmd*7] != 32'd0)
			ncmd++;  // Kind 0 ends the list
		repeat (16)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int t = 0; t < ncmd; t++)
		begin
			test_errors = 0;
			for (int k = 0; k < 7; k++)
				w[k] = cmds[t*7+k];
			kind = w[0];
			case (kind)
				32'd1: issue(w[1][1:0], 1'b0, w[2], w[3], w[4], w[5]);
				32'd2: issue(w[1][1:0], 1'b1, w[2], w[3], w[4], w[5]);
				32'd3: apb(1'b0, w[2][7:0], 32'd0, w[6]);
				32'd4: apb(1'b1, w[2][7:0], w[4], 32'd0);
				32'd5: issue(w[1][1:0], 1'b1, w[2], w[3], $random(seed), $random(seed));
				default:
				begin
					$display("Command %0d has an unknown kind %0d", t, kind);
					test_errors++;
				end
			endcase
			$display("test %0d kind %0d %s", t, kind, test_errors == 0 ? "passed" : "failed");
			if (test_errors != 0)
				tests_failed++;
			errors += test_errors;
		end
		$display("%0d tests run, %0d failed, %0d errors", ncmd, tests_failed, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog sized from the command count
	initial
	begin
		wait (ncmd > 0);
		#((16 + ncmd * (MISS_LATENCY + 10)) * 100);
		$display("Timeout, the commands did not complete in time");
		$display("Something failed");
		$finish;
	end

endmodule

// File: tb_stimulus.txt
// kind mask addr0 addr1 data0 data1 expected, all hex
// kind 1 load, 2 store, 3 APB read, 4 APB write, 5 store random data, 0 end
2 1 10 0 11111111 0 0
1 1 10 0 0 0 0
2 2 0 23 0 22222222 0
1 2 0 23 0 0 0
2 1 33 0 33333333 0 0
1 2 0 23 0 0 0
2 3 45 56 44444444 55555555 0
1 3 56 45 0 0 0
3 0 10 0 0 0 4
3 0 14 0 0 0 6
3 0 18 0 0 0 5
3 0 1c 0 0 0 5
3 0 20 0 0 0 2
3 0 0 0 0 0 1f
4 0 0 0 1a 0 0
5 1 10 0 0 0 0
1 1 10 0 0 0 0
3 0 10 0 0 0 4
3 0 18 0 0 0 5
3 0 8 0 0 0 0
4 0 14 0 0 0 0
4 0 40 0 0 0 0
3 0 0 0 0 0 1a
4 0 0 0 1f 0 0
4 0 4 0 1 0 0
3 0 10 0 0 0 0
3 0 14 0 0 0 0
3 0 18 0 0 0 0
3 0 1c 0 0 0 0
3 0 20 0 0 0 0
5 3 77 87 0 0 0
1 3 87 77 0 0 0
3 0 10 0 0 0 1
3 0 14 0 0 0 3
3 0 18 0 0 0 2
3 0 1c 0 0 0 5
3 0 20 0 0 0 2
0 0 0 0 0 0 0
